/* gem_sync.f */
verilog/gem_sync_pkg.sv
verilog/gem_frame_decoder.sv
verilog/gem_fiber_align.sv
verilog/gem_sync_mon.sv
verilog/gem_sync_top.sv
test/gem_sync_assertions.sv
test/gem_sync_tb.sv

/* Bender.yml */
package:
  name: gem_sync

sources:
  - verilog/gem_sync_pkg.sv
  - verilog/gem_frame_decoder.sv
  - verilog/gem_fiber_align.sv
  - verilog/gem_sync_mon.sv
  - verilog/gem_sync_top.sv
  - target: test
    files:
      - test/gem_sync_assertions.sv
      - test/gem_sync_tb.sv

/* test/gem_sync_tb.sv */
`timescale 1ns/10ps

module gem_sync_tb;

  // frames per test summed for the watchdog
  localparam int LEN_TESTS = 6 + 111 + 56 + 27 + 47 + 51;
  localparam int WATCHDOG_NS = (LEN_TESTS + 100) * 100; // 100 frames of margin

  localparam gem_sync_pkg::sync_status_t ALL_CLEAN = '{a_synced: 1'b1, b_synced: 1'b1,
    s_synced: 1'b1, a_lostsync: 1'b0, b_lostsync: 1'b0, s_lostsync: 1'b0};

  logic clock;
  logic reset;
  logic clk_lock;
  logic ttc_resync;
  gem_sync_pkg::kchar_t       [gem_sync_pkg::NUM_FIBERS-1:0] rx_data;
  logic                       [gem_sync_pkg::NUM_FIBERS-1:0] rx_charisk;
  logic                       [gem_sync_pkg::NUM_FIBERS-1:0] fiber_enable;
  gem_sync_pkg::fiber_delay_t [gem_sync_pkg::NUM_FIBERS-1:0] fiber_delay;
  gem_sync_pkg::sync_status_t status;

  // stimulus state copied onto the dut inputs every frame
  int   frame_no;   // global bunch counter
  int   skew [4];   // frames each fiber lags behind
  logic lock_cfg;
  logic resync_cfg;
  logic [3:0] enable_cfg;
  gem_sync_pkg::fiber_delay_t [3:0] delay_cfg;
  logic [31:0] rng_state = 32'h42c2_704e;
  int status_errs;
  int bit_errs;

  gem_sync_top #(.LOCK_COUNT(8)) DUT (.*);

  always #50 clock = ~clock; // 100 ns bunch clock

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // separator expected at bunch n in the bc f7 fb fd cycle
  function automatic gem_sync_pkg::kchar_t sep_at(input int n);
    case (((n % 4) + 4) % 4)
      0:       return gem_sync_pkg::K_BC;
      1:       return gem_sync_pkg::K_F7;
      2:       return gem_sync_pkg::K_FB;
      default: return gem_sync_pkg::K_FD;
    endcase
  endfunction

  task automatic check_status(input string name, input gem_sync_pkg::sync_status_t act,
                              input gem_sync_pkg::sync_status_t exp);
    if (act !== exp) begin
      status_errs++;
      $display("FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      bit_errs++;
      $display("FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
    end
  endtask

  // one frame where ovr_mask fibers get ovr_k as a k-char and data_mask fibers get garbage
  task automatic drive_frame(input logic [3:0] ovr_mask, input gem_sync_pkg::kchar_t ovr_k,
                             input logic [3:0] data_mask);
    logic [31:0] r;
    @(posedge clock);
    for (int i = 0; i < 4; i++) begin
      if (ovr_mask[i]) begin
        rx_data[i]    <= ovr_k;
        rx_charisk[i] <= 1'b1;
      end else if (data_mask[i]) begin
        r = lcg_next();
        rx_data[i]    <= r[23:16]; // plain data byte
        rx_charisk[i] <= 1'b0;
      end else begin
        rx_data[i]    <= sep_at(frame_no - skew[i]);
        rx_charisk[i] <= 1'b1;
      end
    end
    clk_lock     <= lock_cfg;
    ttc_resync   <= resync_cfg;
    fiber_enable <= enable_cfg;
    fiber_delay  <= delay_cfg;
    frame_no++;
    @(negedge clock); // status settled here
  endtask

  task automatic run_frames(input int count, input logic check);
    repeat (count) begin
      drive_frame(4'b0000, 8'h00, 4'b0000);
      if (check) check_status("status", status, ALL_CLEAN);
    end
  endtask

  task automatic pulse_resync();
    resync_cfg = 1'b1;
    drive_frame(4'b0000, 8'h00, 4'b0000);
    resync_cfg = 1'b0;
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic reset_idle();
    @(negedge clock);
    check_status("status", status, ALL_CLEAN);
    repeat (5) begin
      @(posedge clock); // idle inputs so no link locks
      @(negedge clock);
      check_status("status", status, ALL_CLEAN);
    end
  endtask

  task automatic clean_cycle();
    run_frames(11, 1'b0); // 8 for lock and 3 of latency
    run_frames(100, 1'b1);
  endtask

  task automatic sequence_error();
    int pos;
    gem_sync_pkg::kchar_t bad;
    pos = 5 + int'((lcg_next() >> 16) % 20);
    run_frames(pos, 1'b1);
    bad = sep_at(frame_no + 1 + int'((lcg_next() >> 16) % 3)); // never the expected one
    drive_frame(4'b0010, bad, 4'b0000);
    run_frames(3, 1'b0); // error reaches status now
    check_bit("a_synced", status.a_synced, 1'b0);
    check_bit("b_synced", status.b_synced, 1'b1);
    run_frames(6, 1'b0);
    check_bit("a_lostsync", status.a_lostsync, 1'b1);
    check_bit("s_lostsync", status.s_lostsync, 1'b1);
    check_bit("b_lostsync", status.b_lostsync, 1'b0);
    check_bit("b_synced", status.b_synced, 1'b1);
    pulse_resync();
    run_frames(20, 1'b1);
  endtask

  task automatic marker_insertion();
    gem_sync_pkg::kchar_t marks [3];
    marks[0] = gem_sync_pkg::K_OVERFLOW;
    marks[1] = gem_sync_pkg::K_BC0;
    marks[2] = gem_sync_pkg::K_RESYNC;
    for (int m = 0; m < 3; m++) begin
      drive_frame(4'b1100, marks[m], 4'b0000); // chamber b only
      check_status("status", status, ALL_CLEAN);
      run_frames(8, 1'b1);
    end
  endtask

  task automatic fiber_deskew();
    skew[3] = 1; // fiber 3 one frame late
    run_frames(10, 1'b0);
    check_bit("b_lostsync", status.b_lostsync, 1'b1);
    check_bit("s_lostsync", status.s_lostsync, 1'b1);
    check_bit("a_lostsync", status.a_lostsync, 1'b0);
    delay_cfg = {2'd0, 2'd1, 2'd1, 2'd1}; // hold back the early fibers
    run_frames(6, 1'b0);
    pulse_resync();
    run_frames(30, 1'b1);
  endtask

  task automatic disabled_fiber();
    enable_cfg = 4'b1011;
    repeat (20) begin
      drive_frame(4'b0000, 8'h00, 4'b0100);
      check_bit("b_synced", status.b_synced, 1'b1);
      check_bit("b_lostsync", status.b_lostsync, 1'b0);
    end
    skew[2] = 2; // fiber 2 relocks out of step with fiber 3
    repeat (20) begin
      drive_frame(4'b0000, 8'h00, 4'b0000);
      // once locked only the enable mask skips chamber b
      check_bit("b_synced", status.b_synced, 1'b1);
      check_bit("b_lostsync", status.b_lostsync, 1'b0);
    end
    lock_cfg = 1'b0; // clock unlock holds the monitor clear
    drive_frame(4'b0000, 8'h00, 4'b0100);
    repeat (10) begin
      drive_frame(4'b0000, 8'h00, 4'b0100);
      check_status("status", status, ALL_CLEAN);
    end
  endtask

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------

  initial begin
    int asrt_errs;
    clock = 1'b0;
    reset = 1'b1;
    clk_lock = 1'b1;
    ttc_resync = 1'b0;
    rx_data = '0;
    rx_charisk = '0;
    fiber_enable = '1;
    fiber_delay = '0;
    frame_no = 0;
    skew = '{0, 0, 0, 0};
    lock_cfg = 1'b1;
    resync_cfg = 1'b0;
    enable_cfg = 4'b1111;
    delay_cfg = '0;
    status_errs = 0;
    bit_errs = 0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    reset_idle();
    clean_cycle();
    sequence_error();
    marker_insertion();
    fiber_deskew();
    disabled_fiber();
    asrt_errs = int'(DUT.u_mon.u_sync_checks.fail_count);
    $display("status errors: %0d, bit errors: %0d, assertion failures: %0d",
             status_errs, bit_errs, asrt_errs);
    if (status_errs + bit_errs + asrt_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule

/* test/gem_sync_assertions.sv */
`timescale 1ns/10ps

module gem_sync_assertions (
  input logic                       clock,
  input logic                       reset,
  input logic                       clear,  // monitor's own clear from reset, lock loss or resync
  input gem_sync_pkg::sync_status_t status
);

  int unsigned fail_count = 0; // assertion failures so far

  // sticky flags only drop on the internal clear
  a_hold_a : assert property (@(posedge clock) status.a_lostsync && !clear |=> status.a_lostsync)
    else begin
      $error("a_lostsync dropped without a clear");
      fail_count++;
    end
  a_hold_b : assert property (@(posedge clock) status.b_lostsync && !clear |=> status.b_lostsync)
    else begin
      $error("b_lostsync dropped without a clear");
      fail_count++;
    end
  a_hold_s : assert property (@(posedge clock) status.s_lostsync && !clear |=> status.s_lostsync)
    else begin
      $error("s_lostsync dropped without a clear");
      fail_count++;
    end

  // chamber a out of sync must leave its sticky mark
  a_lost_a : assert property (@(posedge clock) !status.a_synced && !clear |=> status.a_lostsync)
    else begin
      $error("a_synced low without a_lostsync");
      fail_count++;
    end

  // all synced and nothing lost one clock after reset
  a_reset : assert property (@(posedge clock) reset |=>
      status.a_synced && status.b_synced && status.s_synced &&
      !status.a_lostsync && !status.b_lostsync && !status.s_lostsync)
    else begin
      $error("status not at its reset value after reset");
      fail_count++;
    end

endmodule

bind gem_sync_mon gem_sync_assertions u_sync_checks (
  .clock  (clock),
  .reset  (reset),
  .clear  (clear),
  .status (status)
);

/* verilog/gem_sync_top.sv */
`timescale 1ns/10ps

module gem_sync_top #(
  parameter int LOCK_COUNT = 8 // passed to every frame decoder
) (
  input  logic clock,
  input  logic reset,
  input  logic clk_lock,
  input  logic ttc_resync,
  input  gem_sync_pkg::kchar_t       [gem_sync_pkg::NUM_FIBERS-1:0] rx_data,
  input  logic                       [gem_sync_pkg::NUM_FIBERS-1:0] rx_charisk,
  input  logic                       [gem_sync_pkg::NUM_FIBERS-1:0] fiber_enable,
  input  gem_sync_pkg::fiber_delay_t [gem_sync_pkg::NUM_FIBERS-1:0] fiber_delay,
  output gem_sync_pkg::sync_status_t status
);

  gem_sync_pkg::gem_frame_t [gem_sync_pkg::NUM_FIBERS-1:0] frame_dec; // decoder outputs
  gem_sync_pkg::gem_frame_t [gem_sync_pkg::NUM_FIBERS-1:0] frame_aln; // deskewed frames

  // --------------------------------------------------
  // one decoder per fiber
  // --------------------------------------------------

  for (genvar i = 0; i < gem_sync_pkg::NUM_FIBERS; i++) begin : g_decoder
    gem_frame_decoder #(
      .LOCK_COUNT (LOCK_COUNT)
    ) u_decoder (
      .clock      (clock),
      .reset      (reset),
      .rx_data    (rx_data[i]),
      .rx_charisk (rx_charisk[i]),
      .frame      (frame_dec[i])
    );
  end

  // --------------------------------------------------
  // deskew and monitor
  // --------------------------------------------------

  gem_fiber_align u_align (
    .clock       (clock),
    .reset       (reset),
    .frame_in    (frame_dec),
    .fiber_delay (fiber_delay),
    .frame_out   (frame_aln)
  );

  gem_sync_mon u_mon (
    .clock        (clock),
    .reset        (reset),
    .clk_lock     (clk_lock),
    .ttc_resync   (ttc_resync),
    .frame        (frame_aln),
    .fiber_enable (fiber_enable),
    .status       (status)
  );

endmodule

/* verilog/gem_sync_mon.sv */
`timescale 1ns/10ps

module gem_sync_mon (
  input  logic clock,
  input  logic reset,
  input  logic clk_lock,   // low while the bunch clock is not locked
  input  logic ttc_resync, // clears the sticky flags
  input  gem_sync_pkg::gem_frame_t [gem_sync_pkg::NUM_FIBERS-1:0] frame,
  input  logic [3:0]                  fiber_enable,
  output gem_sync_pkg::sync_status_t  status
);

  logic clear;

  logic                 [gem_sync_pkg::NUM_FIBERS-1:0] marker;  // fc, 1c or 3c on the fiber
  logic                 [gem_sync_pkg::NUM_FIBERS-1:0] is_sep;  // valid separator this clock
  logic                 [gem_sync_pkg::NUM_FIBERS-1:0] sep_err; // separator out of cycle
  logic                 [gem_sync_pkg::NUM_FIBERS-1:0] seeded;  // prediction has locked on
  gem_sync_pkg::kchar_t sep_next  [gem_sync_pkg::NUM_FIBERS];   // predicted separator
  gem_sync_pkg::kchar_t frame_sep [gem_sync_pkg::NUM_FIBERS];   // separator used to advance

  logic [1:0] skip_check;   // per chamber
  logic [1:0] chamber_sync; // per chamber
  logic       super_sync;

  // true for the four frame separators only
  function automatic logic in_table(input gem_sync_pkg::kchar_t k);
    return (k == gem_sync_pkg::K_BC) || (k == gem_sync_pkg::K_F7) ||
           (k == gem_sync_pkg::K_FB) || (k == gem_sync_pkg::K_FD);
  endfunction

  // next separator in the bc, f7, fb, fd cycle
  function automatic gem_sync_pkg::kchar_t sep_succ(input gem_sync_pkg::kchar_t k);
    case (k)
      gem_sync_pkg::K_BC: return gem_sync_pkg::K_F7;
      gem_sync_pkg::K_F7: return gem_sync_pkg::K_FB;
      gem_sync_pkg::K_FB: return gem_sync_pkg::K_FD;
      default:            return gem_sync_pkg::K_BC; // after fd
    endcase
  endfunction

  // --------------------------------------------------
  // internal clear
  // --------------------------------------------------

  // any of these restarts the monitor state
  assign clear = reset || !clk_lock || ttc_resync;

  // --------------------------------------------------
  // separator cycle
  // --------------------------------------------------

  always_comb begin
    for (int i = 0; i < gem_sync_pkg::NUM_FIBERS; i++) begin
      marker[i] = frame[i].overflow || frame[i].bc0 || frame[i].resync;
      is_sep[i] = frame[i].valid && in_table(frame[i].kchar); // markers are never in the table
      // markers and unknown chars stand in for the expected separator,
      // so one bad frame does not throw the cycle off for good
      frame_sep[i] = is_sep[i] ? frame[i].kchar : sep_next[i];
      sep_err[i]   = seeded[i] && is_sep[i] && (frame[i].kchar != sep_next[i]);
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < gem_sync_pkg::NUM_FIBERS; i++) begin
      if (clear) begin
        seeded[i]   <= 1'b0;
        sep_next[i] <= gem_sync_pkg::K_BC;
      end else if (seeded[i] || is_sep[i]) begin // first separator seeds, unchecked
        seeded[i]   <= 1'b1;
        sep_next[i] <= sep_succ(frame_sep[i]);
      end
    end
  end

  // --------------------------------------------------
  // sync checks
  // --------------------------------------------------

  // chamber c owns fibers 2c and 2c+1
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      skip_check[c] = marker[2*c] || marker[2*c+1] ||
                      !(frame[2*c].link_good && frame[2*c+1].link_good) ||
                      !(&fiber_enable[2*c +: 2]);
      chamber_sync[c] = skip_check[c] ||
                        (!sep_err[2*c] && !sep_err[2*c+1] &&
                         (frame[2*c].kchar == frame[2*c+1].kchar));
    end
  end

  // fiber 0 stands for chamber a, fiber 2 for chamber b
  assign super_sync = ((frame[0].kchar == frame[2].kchar) && (&chamber_sync)) || (|marker);

  // --------------------------------------------------
  // sticky flags
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (clear) begin
      status <= gem_sync_pkg::STATUS_RESET;
    end else begin
      status.a_synced   <= chamber_sync[0];
      status.b_synced   <= chamber_sync[1];
      status.s_synced   <= super_sync;
      status.a_lostsync <= status.a_lostsync | ~chamber_sync[0];
      status.b_lostsync <= status.b_lostsync | ~chamber_sync[1];
      status.s_lostsync <= status.s_lostsync | ~status.s_synced; // one clock behind s_synced
    end
  end

endmodule

/* verilog/gem_fiber_align.sv */
`timescale 1ns/10ps

module gem_fiber_align (
  input  logic clock,
  input  logic reset,
  input  gem_sync_pkg::gem_frame_t   [gem_sync_pkg::NUM_FIBERS-1:0] frame_in,
  input  gem_sync_pkg::fiber_delay_t [gem_sync_pkg::NUM_FIBERS-1:0] fiber_delay,
  output gem_sync_pkg::gem_frame_t   [gem_sync_pkg::NUM_FIBERS-1:0] frame_out
);

  // one stage per possible delay value, tap 0 is the plain register
  localparam int DEPTH = 4;

  // per-fiber shift chain, index 0 is the newest frame
  gem_sync_pkg::gem_frame_t [DEPTH-1:0] chain [gem_sync_pkg::NUM_FIBERS];

  // --------------------------------------------------
  // delay chains
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < gem_sync_pkg::NUM_FIBERS; i++) begin
        chain[i] <= '0; // valid and link_good low downstream
      end
    end else begin
      for (int i = 0; i < gem_sync_pkg::NUM_FIBERS; i++) begin
        chain[i][0] <= frame_in[i];
        for (int d = 1; d < DEPTH; d++) begin
          chain[i][d] <= chain[i][d-1]; // shift toward the oldest tap
        end
      end
    end
  end

  // --------------------------------------------------
  // output tap
  // --------------------------------------------------

  // early fibers take a later tap so all fibers line up at the monitor
  // latency is 1 + fiber_delay[i] clocks
  always_comb begin
    for (int i = 0; i < gem_sync_pkg::NUM_FIBERS; i++) begin
      frame_out[i] = chain[i][fiber_delay[i]];
    end
  end

endmodule

/* verilog/gem_frame_decoder.sv */
`timescale 1ns/10ps

module gem_frame_decoder #(
  parameter int LOCK_COUNT = 8 // k-chars in a row before the link counts as good
) (
  input  logic                     clock,
  input  logic                     reset,
  input  gem_sync_pkg::kchar_t     rx_data,    // one byte per bunch clock
  input  logic                     rx_charisk, // byte is a control character
  output gem_sync_pkg::gem_frame_t frame
);

  // counter wide enough to hold LOCK_COUNT itself
  localparam int CNT_W = $clog2(LOCK_COUNT + 1);
  localparam logic [CNT_W-1:0] LOCK_MAX = CNT_W'(LOCK_COUNT);

  logic [CNT_W-1:0] lock_cnt;  // consecutive control characters so far
  logic [CNT_W-1:0] cnt_next;
  logic             lock_next; // link_good for the byte now arriving
  logic             is_overflow;
  logic             is_bc0;
  logic             is_resync;

  // --------------------------------------------------
  // link lock
  // --------------------------------------------------

  // a data byte restarts the count, control chars count up and hold at the top
  always_comb begin
    if (!rx_charisk) begin
      cnt_next = '0;
    end else if (lock_cnt == LOCK_MAX) begin
      cnt_next = lock_cnt;
    end else begin
      cnt_next = lock_cnt + 1'b1;
    end
  end

  assign lock_next = (cnt_next == LOCK_MAX); // drops on the first data byte

  always_ff @(posedge clock) begin
    if (reset) begin
      lock_cnt <= '0;
    end else begin
      lock_cnt <= cnt_next;
    end
  end

  // --------------------------------------------------
  // marker classification
  // --------------------------------------------------

  // a marker needs the k flag, a data byte of the same value is payload
  assign is_overflow = rx_charisk && (rx_data == gem_sync_pkg::K_OVERFLOW);
  assign is_bc0      = rx_charisk && (rx_data == gem_sync_pkg::K_BC0);
  assign is_resync   = rx_charisk && (rx_data == gem_sync_pkg::K_RESYNC);

  // one register stage from rx byte to frame
  always_ff @(posedge clock) begin
    if (reset) begin
      frame <= '0; // invalid, not locked, no markers
    end else begin
      frame.kchar     <= rx_data;
      frame.valid     <= rx_charisk && lock_next;
      frame.overflow  <= is_overflow;
      frame.bc0       <= is_bc0;
      frame.resync    <= is_resync;
      frame.link_good <= lock_next;
    end
  end

endmodule

/* verilog/gem_sync_pkg.sv */
package gem_sync_pkg;

  // two chambers (a, b), two optical fibers each
  localparam int NUM_FIBERS = 4;

  typedef logic [7:0] kchar_t;       // 8b/10b control character
  typedef logic [1:0] fiber_delay_t; // extra deskew clocks, 0 to 3

  // --------------------------------------------------
  // control characters
  // --------------------------------------------------

  // frame separators in cycle order, one per bunch crossing
  localparam kchar_t K_BC = 8'hBC;
  localparam kchar_t K_F7 = 8'hF7;
  localparam kchar_t K_FB = 8'hFB;
  localparam kchar_t K_FD = 8'hFD;

  // markers sent in place of the expected separator
  localparam kchar_t K_OVERFLOW = 8'hFC; // more clusters than fit in the frame
  localparam kchar_t K_BC0      = 8'h1C; // bunch crossing zero
  localparam kchar_t K_RESYNC   = 8'h3C; // optohybrid resync

  // --------------------------------------------------
  // per-fiber frame and monitor status
  // --------------------------------------------------

  typedef struct packed {
    kchar_t kchar;     // last byte seen on the fiber
    logic   valid;     // control character on a locked link
    logic   overflow;
    logic   bc0;
    logic   resync;
    logic   link_good; // enough k-chars in a row
  } gem_frame_t;

  typedef struct packed {
    logic a_synced;   // fibers of chamber a agree
    logic b_synced;   // fibers of chamber b agree
    logic s_synced;   // both chambers agree
    logic a_lostsync; // sticky copies
    logic b_lostsync;
    logic s_lostsync;
  } sync_status_t;

  // all synced, nothing lost
  localparam sync_status_t STATUS_RESET = 6'b111_000;

endpackage
